//--- hw/aes_key_settings.svh
`ifndef AES_KEY_SETTINGS_SVH
`define AES_KEY_SETTINGS_SVH

// Generated round keys for AES-128; round 0 is the cipher key itself.
`define AES_NUM_ROUNDS 10

// 32-bit words in one 128-bit key.
`define AES_WORDS_PER_KEY 4

// Round constant for the first generated round.
`define AES_RCON_INIT 8'h01

// Reduction byte of x^8 + x^4 + x^3 + x + 1.
`define AES_RCON_POLY 8'h1b

`endif

//--- hw/aes_types_pkg.sv
`include "aes_key_settings.svh"

package aes_types_pkg;

  typedef logic [7:0] byte_t;

  typedef logic [31:0] word_t;

  // Word 0 sits in the top 32 bits, as in FIPS-197.
  typedef logic [`AES_WORDS_PER_KEY*32-1:0] block_t;

  typedef logic [$clog2(`AES_NUM_ROUNDS+1)-1:0] round_idx_t;

endpackage

//--- hw/key_sched_pkg.sv
package key_sched_pkg;

  // IDLE until the first start, DONE once round 10 is stored.
  typedef enum logic [1:0] {
    IDLE,
    EXPAND,
    DONE
  } sched_state_e;

  typedef logic [7:0] rcon_t;

endpackage

//--- hw/aes_sbox.sv
`timescale 1ns/1ps

module aes_sbox
  import aes_types_pkg::*;
(
  input  byte_t in_i,
  output byte_t out_o
);

  // Forward substitution table, row by row.
  localparam byte_t SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  assign out_o = SBOX[in_i];

endmodule

//--- hw/key_round_step.sv
`timescale 1ns/1ps
`include "aes_key_settings.svh"

module key_round_step
  import aes_types_pkg::*;
  import key_sched_pkg::*;
(
  input  block_t cur_key_i,
  input  rcon_t  rcon_i,
  output block_t next_key_o
);

  localparam int NW = `AES_WORDS_PER_KEY;

  word_t cur_w  [NW];
  word_t next_w [NW];
  word_t rot_word;
  word_t sub_word;
  word_t g_word;
  byte_t rot_bytes [4];
  byte_t sub_bytes [4];

  // Word 0 is the most significant word of the block.
  always_comb begin
    for (int i = 0; i < NW; i++) begin
      cur_w[i] = cur_key_i[32*(NW-1-i) +: 32];
    end
  end

  // RotWord moves the top byte to the bottom.
  assign rot_word = {cur_w[NW-1][23:0], cur_w[NW-1][31:24]};

  for (genvar b = 0; b < 4; b++) begin : g_sbox
    assign rot_bytes[b] = rot_word[8*b +: 8];

    aes_sbox sbox_inst (
      .in_i  (rot_bytes[b]),
      .out_o (sub_bytes[b])
    );
  end

  assign sub_word = {sub_bytes[3], sub_bytes[2], sub_bytes[1], sub_bytes[0]};
  assign g_word   = sub_word ^ {rcon_i, 24'h000000};

  // Each new word chains off the one before it.
  always_comb begin
    next_w[0] = cur_w[0] ^ g_word;
    for (int i = 1; i < NW; i++) begin
      next_w[i] = cur_w[i] ^ next_w[i-1];
    end
  end

  always_comb begin
    for (int i = 0; i < NW; i++) begin
      next_key_o[32*(NW-1-i) +: 32] = next_w[i];
    end
  end

endmodule

//--- hw/key_sched_ctrl.sv
`timescale 1ns/1ps
`include "aes_key_settings.svh"

module key_sched_ctrl
  import aes_types_pkg::*;
  import key_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  block_t     key_i,
  input  block_t     next_key_i,
  output block_t     cur_key_o,
  output rcon_t      rcon_o,
  output logic       wr_en_o,
  output round_idx_t wr_round_o,
  output block_t     wr_key_o,
  output logic       busy_o,
  output logic       ready_o
);

  sched_state_e state_q;
  sched_state_e state_d;
  round_idx_t   round_q;
  round_idx_t   round_nxt;
  rcon_t        rcon_q;
  byte_t        rcon_dbl;
  block_t       key_q;
  logic         accept;
  logic         expanding;
  logic         last_round;

  // Starts are dropped while an expansion is running.
  assign expanding  = (state_q == EXPAND);
  assign accept     = start_i && !expanding;
  assign round_nxt  = round_q + round_idx_t'(1);
  assign last_round = (round_nxt == round_idx_t'(`AES_NUM_ROUNDS));

  // Doubling in GF(2^8).
  assign rcon_dbl = {rcon_q[6:0], 1'b0} ^ ({8{rcon_q[7]}} & `AES_RCON_POLY);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: begin
        if (accept) begin
          state_d = EXPAND;
        end
      end
      EXPAND: begin
        if (last_round) begin
          state_d = DONE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      round_q <= '0;
      rcon_q  <= `AES_RCON_INIT;
    end else begin
      state_q <= state_d;
      if (accept) begin
        round_q <= '0;
        rcon_q  <= `AES_RCON_INIT;
      end else if (expanding) begin
        round_q <= round_nxt;
        rcon_q  <= rcon_dbl;
      end
    end
  end

  // Working key holds the round key numbered round_q.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      key_q <= key_i;
    end else if (expanding) begin
      key_q <= next_key_i;
    end
  end

  assign cur_key_o = key_q;
  assign rcon_o    = rcon_q;

  // Round 0 goes straight in from key_i on the accepting edge.
  assign wr_en_o    = accept || expanding;
  assign wr_round_o = accept ? round_idx_t'(0) : round_nxt;
  assign wr_key_o   = accept ? key_i : next_key_i;

  assign busy_o  = expanding;
  assign ready_o = (state_q == DONE);

endmodule

//--- hw/round_key_store.sv
`timescale 1ns/1ps
`include "aes_key_settings.svh"

module round_key_store
  import aes_types_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       wr_en_i,
  input  round_idx_t wr_round_i,
  input  block_t     wr_key_i,
  input  round_idx_t rd_round_i,
  output block_t     rd_key_o
);

  localparam int NK = `AES_NUM_ROUNDS + 1;

  block_t           mem_q [NK];
  logic   [NK-1:0]  valid_q;
  logic             wr_ok;
  logic             rd_ok;

  assign wr_ok = wr_en_i && (wr_round_i < round_idx_t'(NK));
  assign rd_ok = (rd_round_i < round_idx_t'(NK)) && valid_q[rd_round_i];

  always_ff @(posedge clk_i) begin
    if (wr_ok) begin
      mem_q[wr_round_i] <= wr_key_i;
    end
  end

  // Tracks which entries have been written since reset.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (wr_ok) begin
      valid_q[wr_round_i] <= 1'b1;
    end
  end

  // Unwritten or out of range rounds read as zero.
  assign rd_key_o = rd_ok ? mem_q[rd_round_i] : '0;

endmodule

//--- hw/aes_key_expand_top.sv
`timescale 1ns/1ps

module aes_key_expand_top
  import aes_types_pkg::*;
  import key_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  block_t     key_i,
  input  round_idx_t rd_round_i,
  output block_t     rd_key_o,
  output logic       busy_o,
  output logic       ready_o
);

  block_t     cur_key;
  block_t     next_key;
  rcon_t      rcon;
  logic       wr_en;
  round_idx_t wr_round;
  block_t     wr_key;

  key_sched_ctrl key_sched_ctrl_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .key_i      (key_i),
    .next_key_i (next_key),
    .cur_key_o  (cur_key),
    .rcon_o     (rcon),
    .wr_en_o    (wr_en),
    .wr_round_o (wr_round),
    .wr_key_o   (wr_key),
    .busy_o     (busy_o),
    .ready_o    (ready_o)
  );

  // One full round of the schedule per clock.
  key_round_step key_round_step_inst (
    .cur_key_i  (cur_key),
    .rcon_i     (rcon),
    .next_key_o (next_key)
  );

  round_key_store round_key_store_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_en_i    (wr_en),
    .wr_round_i (wr_round),
    .wr_key_i   (wr_key),
    .rd_round_i (rd_round_i),
    .rd_key_o   (rd_key_o)
  );

endmodule

//--- tb/aes_key_expand_chk.sv
`timescale 1ns/1ps
`include "aes_key_settings.svh"

module aes_key_expand_chk
  import key_sched_pkg::*;
(
  input logic clk_i,
  input logic rst_ni,
  input logic start_i,
  input logic busy_o,
  input logic ready_o
);

  sched_state_e seen_state;
  logic         accept;
  int           assert_fails = 0;

  // Scheduler state as it shows at the ports.
  assign seen_state = busy_o ? EXPAND : (ready_o ? DONE : IDLE);
  assign accept     = start_i && (seen_state != EXPAND);

  flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(busy_o && ready_o))
    else begin
      assert_fails++;
      $error("busy_o and ready_o are high together");
    end

  // Flags change just after an edge, so the sampled ready_o shows one clock later.
  ready_after_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> busy_o [*`AES_NUM_ROUNDS] ##1 ready_o)
    else begin
      assert_fails++;
      $error("ready_o not high the expected cycles after an accepted start");
    end

  // A rise of ready_o needs a start exactly that many cycles back.
  ready_only_after_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ready_o) |-> $past(accept, `AES_NUM_ROUNDS + 1))
    else begin
      assert_fails++;
      $error("ready_o rose without an accepted start at the expected edge");
    end

  ready_low_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !ready_o)
    else begin
      assert_fails++;
      $error("ready_o is high right after reset");
    end

endmodule

bind aes_key_expand_top aes_key_expand_chk aes_key_expand_chk_inst (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .start_i (start_i),
  .busy_o  (busy_o),
  .ready_o (ready_o)
);

//--- tb/aes_key_expand_tb.sv
`timescale 1ns/1ps
`include "aes_key_settings.svh"

module aes_key_expand_tb
  import aes_types_pkg::*;
();

  localparam int SEED     = 50572;
  localparam int NUM_RAND = 20;
  localparam int NR       = `AES_NUM_ROUNDS;
  localparam int READY_LIMIT = NR + 20;
  // Round keys read back by all tests together.
  localparam int KEYS_READ = 2 + (NR + 1) * (NUM_RAND + 4);
  localparam longint TIMEOUT_NS = (KEYS_READ * 14 + 100) * 20;

  localparam byte_t  AFFINE_C  = 8'h63;
  localparam block_t FIPS_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam block_t FIPS_RK10 = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;

  logic       clk_i;
  logic       rst_ni;
  logic       start_i;
  block_t     key_i;
  round_idx_t rd_round_i;
  block_t     rd_key_o;
  logic       busy_o;
  logic       ready_o;

  byte_t  sbox_tbl   [256];
  block_t model_keys [NR+1];
  int     errors;
  int     checks;
  int     tests;
  int     tests_failed;
  int     test_err_base;
  string  cur_test;

  aes_key_expand_top aes_key_expand_top_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .key_i      (key_i),
    .rd_round_i (rd_round_i),
    .rd_key_o   (rd_key_o),
    .busy_o     (busy_o),
    .ready_o    (ready_o)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #10 clk_i = ~clk_i;

  function automatic byte_t gf_mul(input byte_t a, input byte_t b);
    byte_t p;
    byte_t x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ x;
      end
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // S-box from the field inverse and the affine map.
  task automatic build_sbox_table();
    byte_t a;
    byte_t inv;
    for (int v = 0; v < 256; v++) begin
      a   = byte_t'(v);
      inv = 8'h01;
      // a^254 is the inverse; zero stays zero.
      for (int k = 0; k < 254; k++) begin
        inv = gf_mul(inv, a);
      end
      for (int i = 0; i < 8; i++) begin
        sbox_tbl[v][i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8]
                         ^ inv[(i+7)%8] ^ AFFINE_C[i];
      end
    end
  endtask

  task automatic expand_model(input block_t key);
    word_t w [4*(NR+1)];
    word_t t;
    byte_t rc;
    for (int i = 0; i < 4; i++) begin
      w[i] = key[127-32*i -: 32];
    end
    rc = 8'h01;
    for (int i = 4; i < 4*(NR+1); i++) begin
      t = w[i-1];
      if (i % 4 == 0) begin
        t = {sbox_tbl[t[23:16]], sbox_tbl[t[15:8]], sbox_tbl[t[7:0]], sbox_tbl[t[31:24]]}
            ^ {rc, 24'h000000};
        rc = gf_mul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ t;
    end
    for (int r = 0; r <= NR; r++) begin
      model_keys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
  endtask

  function automatic block_t random_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic check_block(input string name, input block_t got, input block_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    test_err_base = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == test_err_base) begin
      $display("test %s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", cur_test, errors - test_err_base);
    end
  endtask

  // Returns on the falling edge just after the accepting edge.
  task automatic start_key(input block_t key);
    @(negedge clk_i);
    key_i   = key;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready_o !== 1'b1 && n < READY_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (ready_o !== 1'b1) begin
      errors++;
      $display("error: ready_o did not rise within %0d cycles", READY_LIMIT);
    end
  endtask

  task automatic read_round(input int r, output block_t val);
    @(negedge clk_i);
    rd_round_i = round_idx_t'(r);
    #1;
    val = rd_key_o;
  endtask

  task automatic check_all_rounds();
    block_t got;
    for (int r = 0; r <= NR; r++) begin
      read_round(r, got);
      check_block($sformatf("rd_key_o[%0d]", r), got, model_keys[r]);
    end
  endtask

  task automatic expand_and_check(input block_t key);
    start_key(key);
    wait_ready();
    expand_model(key);
    check_all_rounds();
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    block_t key_a;
    block_t key_b;
    block_t got;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    tests_failed = 0;
    rst_ni       = 1'b0;
    start_i      = 1'b0;
    key_i        = '0;
    rd_round_i   = '0;
    void'($urandom(SEED));
    build_sbox_table();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    begin_test("reset");
    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b0);
    end_test();

    begin_test("known_key");
    start_key(FIPS_KEY);
    wait_ready();
    read_round(NR, got);
    check_block("rd_key_o[10]", got, FIPS_RK10);
    read_round(0, got);
    check_block("rd_key_o[0]", got, FIPS_KEY);
    expand_model(FIPS_KEY);
    check_all_rounds();
    end_test();

    begin_test("random_keys");
    for (int i = 0; i < NUM_RAND; i++) begin
      key_a = random_block();
      expand_and_check(key_a);
    end
    end_test();

    begin_test("timing");
    start_key(random_block());
    // Step n is n rising edges past the accepting one.
    for (int n = 0; n <= NR; n++) begin
      if (n > 0) begin
        @(negedge clk_i);
      end
      check_flag("busy_o", busy_o, n < NR);
      check_flag("ready_o", ready_o, n == NR);
    end
    start_key(random_block());
    check_flag("ready_o", ready_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b1);
    wait_ready();
    end_test();

    begin_test("start_while_busy");
    key_a = random_block();
    key_b = ~key_a;
    start_key(key_a);
    repeat (3) @(negedge clk_i);
    start_key(key_b);
    check_flag("busy_o", busy_o, 1'b1);
    wait_ready();
    expand_model(key_a);
    check_all_rounds();
    end_test();

    begin_test("restart");
    key_a = random_block();
    key_b = random_block();
    expand_and_check(key_a);
    expand_and_check(key_b);
    end_test();

    if (aes_key_expand_top_inst.aes_key_expand_chk_inst.assert_fails != 0) begin
      errors += aes_key_expand_top_inst.aes_key_expand_chk_inst.assert_fails;
      $display("error: %0d checker assertions failed",
               aes_key_expand_top_inst.aes_key_expand_chk_inst.assert_fails);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+hw
hw/aes_types_pkg.sv
hw/key_sched_pkg.sv
hw/aes_sbox.sv
hw/key_round_step.sv
hw/key_sched_ctrl.sv
hw/round_key_store.sv
hw/aes_key_expand_top.sv
tb/aes_key_expand_chk.sv
tb/aes_key_expand_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= aes_key_expand_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := ERRORS FOUND
PASS_MSG := NO ERRORS
SIM      := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "test: failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test: no result in $(LOG)"; exit 1; \
	else \
	  echo "test: passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
